//--- Bender.yml
package:
  name: fetch_frontend

export_include_dirs:
  - .

sources:
  - fetch_pkg.sv
  - fetch_pc_gen.sv
  - fetch_stage.sv
  - fetch_top.sv
  - target: simulation
    files:
      - fetch_checker.sv
      - fetch_tb.sv

//--- fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker import fetch_pkg::*; (
    input logic      clk,
    input logic      resetn,
    input logic      req,
    input logic      addr_ok,
    input logic      data_ok,
    input logic      br_stall,
    input logic      kill,
    input logic      to_id_valid,
    input if_to_id_t to_id,
    input logic      id_allowin
);

    int outstanding;
    int fail_count = 0;

    // requests taken by memory and not yet answered
    always_ff @(posedge clk) begin
        if (!resetn) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(req & addr_ok) - int'(data_ok);
        end
    end

    req_quiet_in_reset: assert property (@(posedge clk) !resetn |=> !req)
        else begin
            fail_count++;
            $error("req high in a reset cycle");
        end

    req_held_by_stall: assert property (@(posedge clk) disable iff (!resetn)
        br_stall |-> !req)
        else begin
            fail_count++;
            $error("req high while br.stall is set");
        end

    // a held instruction only goes away through a transfer or a redirect
    output_held: assert property (@(posedge clk) disable iff (!resetn)
        $past(to_id_valid && !id_allowin) && !kill |-> to_id_valid && $stable(to_id))
        else begin
            fail_count++;
            $error("to_id changed under back-pressure");
        end

    data_has_request: assert property (@(posedge clk) disable iff (!resetn)
        data_ok |-> outstanding != 0)
        else begin
            fail_count++;
            $error("data_ok with no request in flight");
        end

endmodule

bind fetch_top fetch_checker u_checker (
    .clk         (clk),
    .resetn      (resetn),
    .req         (req),
    .addr_ok     (addr_ok),
    .data_ok     (data_ok),
    .br_stall    (br.stall),
    .kill        (redirect_now | flush),
    .to_id_valid (to_id_valid),
    .to_id       (to_id),
    .id_allowin  (id_allowin)
);

//--- fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// pc held in reset sits one word below the first fetch address
`define FETCH_RESET_PC 32'h1BFF_FFFC

// byte increment between sequential fetches
`define FETCH_WORD_STEP 32'd4

// stale responses that can be tracked at once is 2**W - 1
`define FETCH_CANCEL_W 4

`endif

//--- fetch_pc_gen.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  csr_redirect_t csr,
    input  branch_t       br,
    input  logic          accept,
    input  logic          advance,
    output addr_t         pc,
    output addr_t         next_pc,
    output logic          redirect_now
);

    // redirect kinds with index 0 at the highest priority
    localparam int NUM_SRC = 3;

    logic [NUM_SRC-1:0] hit;
    addr_t              hit_addr [NUM_SRC];
    logic [NUM_SRC-1:0] pend;
    addr_t              saved [NUM_SRC];

    assign hit[0]      = csr.ertn_valid;
    assign hit[1]      = csr.ex_valid;
    assign hit[2]      = br.taken;
    assign hit_addr[0] = csr.era;
    assign hit_addr[1] = csr.ex_entry;
    assign hit_addr[2] = br.target;

    assign redirect_now = |hit;

    // a redirect seen on an accept edge is either fetched now or overruled,
    // so it is only held when memory did not take a request
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pend <= '0;
        end else begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (accept) begin
                    pend[i] <= 1'b0;
                end else if (hit[i]) begin
                    pend[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SRC; i++) begin
            if (hit[i]) begin
                saved[i] <= hit_addr[i];
            end
        end
    end

    // walk from lowest priority up so later matches win
    // held target beats the live one of the same kind
    always_comb begin
        next_pc = pc + `FETCH_WORD_STEP;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (hit[i]) begin
                next_pc = hit_addr[i];
            end
            if (pend[i]) begin
                next_pc = saved[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc <= `FETCH_RESET_PC;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

endmodule

//--- fetch_pkg.sv
`include "fetch_defines.svh"

package fetch_pkg;

    // byte address on the fetch side
    typedef logic [31:0] addr_t;

    // raw instruction word from memory
    typedef logic [31:0] inst_t;

    // outstanding responses that must be dropped
    typedef logic [`FETCH_CANCEL_W-1:0] cancel_cnt_t;

    // exception entry and return from writeback
    typedef struct packed {
        logic  ertn_valid;
        logic  ex_valid;
        addr_t ex_entry;
        addr_t era;
    } csr_redirect_t;

    // branch outcome from decode
    // stall holds fetch until the branch resolves
    typedef struct packed {
        logic  taken;
        logic  stall;
        addr_t target;
    } branch_t;

    // fetched instruction handed to decode
    typedef struct packed {
        inst_t inst;
        addr_t pc;
        logic  adef;
    } if_to_id_t;

endpackage

//--- fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage import fetch_pkg::*; (
    input  logic      clk,
    input  logic      resetn,
    // instruction memory
    output logic      req,
    output addr_t     addr,
    input  logic      addr_ok,
    input  logic      data_ok,
    input  inst_t     rdata,
    // decode side
    input  logic      id_allowin,
    input  logic      flush,
    input  logic      br_stall,
    // pc generator
    input  logic      redirect_now,
    input  addr_t     pc,
    input  addr_t     next_pc,
    output logic      accept,
    output logic      advance,
    // to decode
    output logic      to_id_valid,
    output if_to_id_t to_id
);

    logic        started;
    logic        halted;
    logic        valid;
    logic        kill;
    logic        allowin;
    logic        ready_go;
    logic        live_data;
    cancel_cnt_t cancel_cnt;
    logic        cancel_any;
    logic        cnt_inc;
    logic        cnt_dec;
    logic        pre_cancel;
    logic        buf_valid;
    inst_t       buf_inst;

    assign kill = redirect_now | flush;

    // a response belongs to the stage only once every stale one has drained
    assign cancel_any = |cancel_cnt;
    assign live_data  = data_ok & ~cancel_any & ~pre_cancel;

    assign ready_go = live_data | buf_valid;
    assign allowin  = ~valid | (ready_go & id_allowin);

    assign req    = started & ~halted & allowin & ~br_stall & ~pre_cancel;
    assign addr   = next_pc;
    assign accept = req & addr_ok;

    // flush without a new target throws away the request taken this cycle
    assign advance = accept & (redirect_now | ~flush);

    // keeps req low through the reset cycles
    always_ff @(posedge clk) begin
        if (!resetn) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    // fetch sleeps after a flush until some redirect gives a new path
    always_ff @(posedge clk) begin
        if (!resetn) begin
            halted <= 1'b0;
        end else if (redirect_now) begin
            halted <= 1'b0;
        end else if (flush) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (allowin | kill) begin
            valid <= advance;
        end
    end

    // request in flight whose answer is now stale
    assign cnt_inc = kill & valid & ~ready_go;
    assign cnt_dec = data_ok & cancel_any;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            cancel_cnt <= '0;
        end else begin
            cancel_cnt <= cancel_cnt + cancel_cnt_t'(cnt_inc) - cancel_cnt_t'(cnt_dec);
        end
    end

    // marks the newest accepted request as dead
    // nothing else may issue before its answer comes back
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pre_cancel <= 1'b0;
        end else if (accept & ~advance) begin
            pre_cancel <= 1'b1;
        end else if (pre_cancel & data_ok & ~cancel_any) begin
            pre_cancel <= 1'b0;
        end
    end

    // one-entry hold for data that arrives while decode is stalled
    always_ff @(posedge clk) begin
        if (!resetn) begin
            buf_valid <= 1'b0;
        end else if (kill | id_allowin) begin
            buf_valid <= 1'b0;
        end else if (valid & live_data) begin
            buf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (valid & live_data & ~id_allowin) begin
            buf_inst <= rdata;
        end
    end

    // data passes straight through in its data_ok cycle
    assign to_id_valid = valid & ready_go & ~kill;

    always_comb begin
        to_id.inst = buf_valid ? buf_inst : rdata;
        to_id.pc   = pc;
        to_id.adef = |pc[1:0];
    end

endmodule

//--- fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_defines.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    RESET_CYCLES = 10;
    localparam int    NUM_ROWS     = 11;
    localparam int    ROW_BUDGET   = 200;
    localparam int    FLUSH_GAP    = 8;
    localparam addr_t FIRST_PC     = 32'h1C00_0000;
    localparam inst_t INST_KEY     = 32'hA5A5_0000;

    localparam logic [2:0] KIND_NONE   = 3'd0;
    localparam logic [2:0] KIND_BRANCH = 3'd1;
    localparam logic [2:0] KIND_EXCEPT = 3'd2;
    localparam logic [2:0] KIND_ERTN   = 3'd3;
    localparam logic [2:0] KIND_FLUSH  = 3'd4;
    localparam logic [2:0] KIND_HOLD   = 3'd5;

    typedef struct packed {
        logic [7:0] wait_n;
        logic [2:0] kind;
        addr_t      target;
        logic [7:0] stall_len;
    } row_t;

    logic          clk;
    logic          resetn;
    logic          req;
    addr_t         addr;
    logic          addr_ok;
    logic          data_ok;
    inst_t         rdata;
    logic          to_id_valid;
    if_to_id_t     to_id;
    logic          id_allowin;
    branch_t       br;
    csr_redirect_t csr;
    logic          flush;

    row_t          rows [NUM_ROWS];
    addr_t         exp_pc;
    logic          quiet;
    int            delivered;
    logic [31:0]   rng;
    int            cycle;
    logic          took_req;
    addr_t         took_addr;
    addr_t         pend_addr [$];
    int            pend_due [$];

    fetch_top u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .req         (req),
        .addr        (addr),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .to_id_valid (to_id_valid),
        .to_id       (to_id),
        .id_allowin  (id_allowin),
        .br          (br),
        .csr         (csr),
        .flush       (flush)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_inst(input string name, input inst_t expected, input inst_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input bit expected, input bit actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        if (u_dut.u_checker.fail_count != 0) begin
            $display("an assertion in the bound checker failed");
            stop_with_failure();
        end
    end

    // decode transfers and memory requests are sampled mid-cycle after the edge inputs settle
    always @(negedge clk) begin
        took_req  = resetn & req & addr_ok;
        took_addr = addr;
        if (resetn && to_id_valid && id_allowin) begin
            if (quiet) begin
                $display("an instruction reached decode while fetch was flushed");
                stop_with_failure();
            end else begin
                check_addr("to_id.pc", exp_pc, to_id.pc);
                check_inst("to_id.inst", exp_pc ^ INST_KEY, to_id.inst);
                check_flag("to_id.adef", exp_pc[1:0] != 2'b00, to_id.adef);
                exp_pc    = exp_pc + `FETCH_WORD_STEP;
                delivered = delivered + 1;
            end
        end
    end

    // in-order memory with random address stalls and 1 to 8 cycles of latency
    always @(posedge clk) begin
        rng = lcg_step(rng);
        if (took_req) begin
            pend_addr.push_back(took_addr);
            pend_due.push_back(cycle + int'(rng[18:16]));
        end
        data_ok <= 1'b0;
        if (pend_addr.size() != 0 && pend_due[0] <= cycle) begin
            data_ok <= 1'b1;
            rdata   <= pend_addr[0] ^ INST_KEY;
            void'(pend_addr.pop_front());
            void'(pend_due.pop_front());
        end
        addr_ok <= rng[22:21] != 2'b00;
        cycle = cycle + 1;
    end

    task automatic wait_for_deliveries(input int count);
        int goal;
        goal = delivered + count;
        while (delivered < goal) begin
            @(posedge clk);
        end
    endtask

    // losing sources get addresses that would be caught if they won
    task automatic drive_redirect(input logic [2:0] kind, input addr_t target);
        case (kind)
            KIND_EXCEPT: begin
                csr <= '{1'b0, 1'b1, target, 32'h0};
                br  <= '{1'b1, 1'b0, target + 32'h2000};
            end
            KIND_ERTN: begin
                csr <= '{1'b1, 1'b1, target + 32'h3000, target};
                br  <= '{1'b1, 1'b0, target + 32'h2000};
            end
            default: begin
                br <= '{1'b1, 1'b0, target};
            end
        endcase
        exp_pc = target;
        quiet  = 1'b0;
        @(posedge clk);
        br  <= '0;
        csr <= '0;
    endtask

    task automatic run_row(input row_t row);
        wait_for_deliveries(int'(row.wait_n));
        if (row.kind == KIND_HOLD) begin
            // decode holds fetch on an unresolved branch
            br.stall <= 1'b1;
            repeat (row.stall_len) @(posedge clk);
            br.stall <= 1'b0;
        end else if (row.stall_len != 8'd0) begin
            id_allowin <= 1'b0;
            repeat (row.stall_len) @(posedge clk);
        end
        if (row.kind == KIND_FLUSH) begin
            flush <= 1'b1;
            quiet = 1'b1;
            @(posedge clk);
            flush      <= 1'b0;
            id_allowin <= 1'b1;
            repeat (FLUSH_GAP) @(posedge clk);
            drive_redirect(KIND_BRANCH, row.target);
        end else if (row.kind inside {KIND_BRANCH, KIND_EXCEPT, KIND_ERTN}) begin
            drive_redirect(row.kind, row.target);
        end
        id_allowin <= 1'b1;
    endtask

    // wait_n, kind, target, stall_len
    // a hold row keeps br.stall high for stall_len cycles
    task automatic load_table();
        rows[0]  = '{8'd6, KIND_NONE,   32'h0000_0000, 8'd0};
        rows[1]  = '{8'd3, KIND_BRANCH, 32'h1C00_0400, 8'd0};
        rows[2]  = '{8'd4, KIND_NONE,   32'h0000_0000, 8'd5};
        rows[3]  = '{8'd2, KIND_EXCEPT, 32'h1C00_8000, 8'd0};
        rows[4]  = '{8'd3, KIND_ERTN,   32'h1C00_0040, 8'd3};
        rows[5]  = '{8'd3, KIND_BRANCH, 32'h1C00_0202, 8'd0};
        rows[6]  = '{8'd4, KIND_NONE,   32'h0000_0000, 8'd1};
        rows[7]  = '{8'd2, KIND_FLUSH,  32'h1C00_1000, 8'd0};
        rows[8]  = '{8'd5, KIND_BRANCH, 32'h1C00_0800, 8'd2};
        rows[9]  = '{8'd3, KIND_HOLD,   32'h0000_0000, 8'd12};
        rows[10] = '{8'd8, KIND_NONE,   32'h0000_0000, 8'd0};
    endtask

    initial begin
        resetn     = 1'b0;
        addr_ok    = 1'b0;
        data_ok    = 1'b0;
        rdata      = '0;
        id_allowin = 1'b1;
        br         = '0;
        csr        = '0;
        flush      = 1'b0;
        rng        = 32'd25;
        cycle      = 0;
        took_req   = 1'b0;
        took_addr  = '0;
        delivered  = 0;
        quiet      = 1'b0;
        exp_pc     = FIRST_PC;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end
        @(negedge clk);
        if (u_dut.u_checker.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #((NUM_ROWS * ROW_BUDGET + RESET_CYCLES) * CLK_PERIOD);
        $display("timeout, the stimulus table did not finish in time");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    // instruction memory
    output logic          req,
    output addr_t         addr,
    input  logic          addr_ok,
    input  logic          data_ok,
    input  inst_t         rdata,
    // decode
    output logic          to_id_valid,
    output if_to_id_t     to_id,
    input  logic          id_allowin,
    // redirect sources
    input  branch_t       br,
    input  csr_redirect_t csr,
    input  logic          flush
);

    logic  accept;
    logic  advance;
    logic  redirect_now;
    addr_t pc;
    addr_t next_pc;

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .resetn       (resetn),
        .csr          (csr),
        .br           (br),
        .accept       (accept),
        .advance      (advance),
        .pc           (pc),
        .next_pc      (next_pc),
        .redirect_now (redirect_now)
    );

    fetch_stage u_stage (
        .clk          (clk),
        .resetn       (resetn),
        .req          (req),
        .addr         (addr),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .id_allowin   (id_allowin),
        .flush        (flush),
        .br_stall     (br.stall),
        .redirect_now (redirect_now),
        .pc           (pc),
        .next_pc      (next_pc),
        .accept       (accept),
        .advance      (advance),
        .to_id_valid  (to_id_valid),
        .to_id        (to_id)
    );

endmodule

//--- list.f
+incdir+.
fetch_pkg.sv
fetch_pc_gen.sv
fetch_stage.sv
fetch_top.sv
fetch_checker.sv
fetch_tb.sv
